// File: rtl/tvgen_defines.svh
// field widths of the page table word and the ring number
// trap vector codes handed to the microcode sequencer
// priority order of the codes is set in the vector encoder

`ifndef TVGEN_DEFINES_SVH
`define TVGEN_DEFINES_SVH

// widths fixed by the memory management architecture
`define TVGEN_PT_W    7     // wpm rpm fpm wip pgu and a two bit ring
`define TVGEN_RING_W  2     // four ring levels
`define TVGEN_TVEC_W  4     // vector width seen by the sequencer

// page table update requests sit low in the code space
`define TVGEN_TV_NONE   4'h0  // no trap pending
`define TVGEN_TV_RDOWN  4'h4  // fetch from a lower ring page
`define TVGEN_TV_WIP    4'h5  // set written in page
`define TVGEN_TV_PGU    4'h6  // set page used

// real traps use the upper half of the code space
`define TVGEN_TV_PGF    4'h8  // page not present at all
`define TVGEN_TV_PVIOL  4'h9  // permission missing for this access type
`define TVGEN_TV_RVIOL  4'hA  // page ring above the current ring
`define TVGEN_TV_PAN    4'hB  // memory did not acknowledge
`define TVGEN_TV_VTRAP  4'hC  // vectored trap request
`define TVGEN_TV_INTRQ  4'hD  // interrupt request
`define TVGEN_TV_FTRAP  4'hF  // forced trap wins over everything

`endif

// File: rtl/tvgen_pkg.sv
// shared types of the trap vector generator
// page table word with a raw view and a decoded field view
// captured access request and external trap pin bundles
// flags produced by the protection checker

`include "tvgen_defines.svh"

package tvgen_pkg;

  // decoded view of the page table word, msb first
  typedef struct packed {
    logic                     wpm;   // write permitted
    logic                     rpm;   // read permitted
    logic                     fpm;   // fetch permitted
    logic                     wip;   // page already written
    logic                     pgu;   // page already used
    logic [`TVGEN_RING_W-1:0] ring;  // ring the page belongs to
  } pt_fields_t;

  // the same seven bits are stored raw and read back as fields
  typedef union packed {
    logic [`TVGEN_PT_W-1:0] raw;     // as it arrives from the page table RAM
    pt_fields_t             fields;  // as the checker decodes it
  } pt_word_u;

  // one memory access slot as seen by the checker
  typedef struct packed {
    logic                     vacc;      // a valid access is in this slot
    logic                     ifetch;    // instruction fetch
    logic                     iwrite;    // data write
    logic                     iind;      // indirect address read
    pt_word_u                 pt;        // page table entry of the target page
    logic [`TVGEN_RING_W-1:0] pcr_ring;  // ring of the running program
  } access_t;

  // external trap pins keep their board polarity
  typedef struct packed {
    logic ftrap_n;  // forced trap, active low
    logic vtrap_n;  // vectored trap, active low
    logic pan;      // access acknowledge, low means no answer
    logic intrq;    // interrupt request, active high
    logic dstop_n;  // stop of the output register, active low
    logic poni;     // paging on
  } ext_trap_t;

  // result of the permission and ring rules
  typedef struct packed {
    logic pgf;      // page fault
    logic wpv;      // write protection violation
    logic ipv;      // indirect protection violation
    logic fpv;      // fetch protection violation
    logic rpv;      // read protection violation
    logic rviol;    // ring violation
    logic rdown;    // ring downgrade on fetch
    logic wip_set;  // written in page must be set
    logic pgu_set;  // page used must be set
    logic restr;    // restricted mode
  } check_t;

endpackage

// File: rtl/tvgen_access_capture.sv
// input register stage of the trap vector generator
// samples the access request and the trap pins on tclk
// stores the page table word into the union of the access struct

`timescale 1ns/1ps

`include "tvgen_defines.svh"

module tvgen_access_capture
  import tvgen_pkg::*;
(
  input  logic                     tclk,
  input  logic                     reset,
  input  logic                     vacc,
  input  logic                     ifetch,
  input  logic                     iwrite,
  input  logic                     iind,
  input  logic [`TVGEN_PT_W-1:0]   pt,
  input  logic [`TVGEN_RING_W-1:0] pcr_ring,
  input  logic                     ftrap_n,
  input  logic                     vtrap_n,
  input  logic                     pan,
  input  logic                     intrq,
  input  logic                     dstop_n,
  input  logic                     poni,
  output access_t                  acc,
  output ext_trap_t                ext
);

  always_ff @(posedge tclk) begin
    if (reset) begin
      acc <= '0;                   // idle slot with ring 0 and an empty page word
      ext <= '{ftrap_n: 1'b1,      // every trap line at its inactive level
               vtrap_n: 1'b1,
               pan:     1'b1,
               intrq:   1'b0,
               dstop_n: 1'b1,
               poni:    1'b0};
    end else begin
      acc.vacc     <= vacc;        // sampled every cycle even while stopped
      acc.ifetch   <= ifetch;
      acc.iwrite   <= iwrite;
      acc.iind     <= iind;
      acc.pt.raw   <= pt;          // written raw and decoded through fields later
      acc.pcr_ring <= pcr_ring;
      ext.ftrap_n  <= ftrap_n;
      ext.vtrap_n  <= vtrap_n;
      ext.pan      <= pan;
      ext.intrq    <= intrq;
      ext.dstop_n  <= dstop_n;     // stop applies to the slot captured with it
      ext.poni     <= poni;
    end
  end

endmodule

// File: rtl/tvgen_protect_check.sv
// combinational permission and ring checker
// decodes the access type from ifetch iwrite and iind
// compares the page ring with the current ring in both directions
// flags page table update cycles and restricted mode

`timescale 1ns/1ps

module tvgen_protect_check
  import tvgen_pkg::*;
(
  input  access_t   acc,
  input  ext_trap_t ext,
  output check_t    chk
);

  pt_fields_t pte;         // page table word seen through the field view
  logic       fetch_n;     // local inverses of the access qualifiers
  logic       write_n;
  logic       ind_n;
  logic       wpm_n;
  logic       rpm_n;
  logic       fpm_n;
  logic       wip_n;
  logic       pgu_n;
  logic [1:0] pring_n;     // inverted page ring bits
  logic [1:0] cring_n;     // inverted current ring bits
  logic       is_write;    // plain write
  logic       is_ind;      // indirect address read
  logic       is_fetch;    // instruction fetch
  logic       is_read;     // plain data read
  logic       ring_above;  // page ring higher than the current ring
  logic       ring_below;  // page ring lower than the current ring

  assign pte = acc.pt.fields;

  assign fetch_n = ~acc.ifetch;
  assign write_n = ~acc.iwrite;
  assign ind_n   = ~acc.iind;
  assign wpm_n   = ~pte.wpm;
  assign rpm_n   = ~pte.rpm;
  assign fpm_n   = ~pte.fpm;
  assign wip_n   = ~pte.wip;
  assign pgu_n   = ~pte.pgu;
  assign pring_n = ~pte.ring;
  assign cring_n = ~acc.pcr_ring;

  // each access type owns exactly one qualifier pattern
  assign is_write = acc.vacc & acc.iwrite & ind_n & fetch_n;
  assign is_ind   = acc.vacc & write_n & acc.iind & fetch_n;
  assign is_fetch = acc.vacc & write_n & ind_n & acc.ifetch;
  assign is_read  = acc.vacc & write_n & ind_n & fetch_n;

  // page ring greater than current ring, split into three product terms
  assign ring_above = (pte.ring[1] & cring_n[1])
                    | (pte.ring[0] & cring_n[1] & cring_n[0])
                    | (pte.ring[1] & pte.ring[0] & cring_n[0]);

  // page ring smaller than current ring, the mirror of the terms above
  assign ring_below = (pring_n[1] & acc.pcr_ring[1])
                    | (pring_n[1] & pring_n[0] & acc.pcr_ring[0])
                    | (pring_n[0] & acc.pcr_ring[1] & acc.pcr_ring[0]);

  assign chk.pgf     = acc.vacc & wpm_n & rpm_n & fpm_n;  // no permission bit at all
  assign chk.wpv     = is_write & wpm_n;
  assign chk.ipv     = is_ind & rpm_n & fpm_n;            // indirect may use read or fetch
  assign chk.fpv     = is_fetch & fpm_n;
  assign chk.rpv     = is_read & rpm_n;
  assign chk.rviol   = acc.vacc & ring_above;
  assign chk.rdown   = is_fetch & pte.fpm & ring_below;   // program drops to the page ring
  assign chk.wip_set = is_write & pte.wpm & wip_n;
  assign chk.pgu_set = acc.vacc & pgu_n;                  // first touch of the page
  assign chk.restr   = ext.poni & cring_n[1];             // rings 0 and 1 with paging on

endmodule

// File: rtl/tvgen_vector_encode.sv
// output stage of the trap vector generator
// priority encoder from check flags and trap pins to one vector code
// registered vector with the protection violation and restricted flags
// the register holds its contents while dstop_n is low

`timescale 1ns/1ps

`include "tvgen_defines.svh"

module tvgen_vector_encode
  import tvgen_pkg::*;
(
  input  logic                     tclk,
  input  logic                     reset,
  input  check_t                   chk,
  input  ext_trap_t                ext,
  output logic [`TVGEN_TVEC_W-1:0] tvec,
  output logic                     pviol,
  output logic                     restr
);

  logic [`TVGEN_TVEC_W-1:0] tvec_next;   // winning code of this slot
  logic                     prot_other;  // protection violation other than page fault
  logic                     pviol_next;

  assign prot_other = chk.wpv | chk.ipv | chk.fpv | chk.rpv;
  assign pviol_next = chk.pgf | prot_other;  // page fault counts as a violation too

  // highest priority first
  always_comb begin
    if (!ext.ftrap_n) begin
      tvec_next = `TVGEN_TV_FTRAP;
    end else if (chk.pgf) begin
      tvec_next = `TVGEN_TV_PGF;
    end else if (prot_other) begin
      tvec_next = `TVGEN_TV_PVIOL;
    end else if (chk.rviol) begin
      tvec_next = `TVGEN_TV_RVIOL;
    end else if (!ext.pan) begin
      tvec_next = `TVGEN_TV_PAN;       // memory gave no acknowledge
    end else if (!ext.vtrap_n) begin
      tvec_next = `TVGEN_TV_VTRAP;
    end else if (ext.intrq) begin
      tvec_next = `TVGEN_TV_INTRQ;
    end else if (chk.rdown) begin
      tvec_next = `TVGEN_TV_RDOWN;     // update requests only when nothing traps
    end else if (chk.wip_set) begin
      tvec_next = `TVGEN_TV_WIP;
    end else if (chk.pgu_set) begin
      tvec_next = `TVGEN_TV_PGU;
    end else begin
      tvec_next = `TVGEN_TV_NONE;
    end
  end

  always_ff @(posedge tclk) begin
    if (reset) begin
      tvec  <= `TVGEN_TV_NONE;
      pviol <= 1'b0;
      restr <= 1'b0;
    end else if (ext.dstop_n) begin  // a low dstop_n freezes all three outputs
      tvec  <= tvec_next;
      pviol <= pviol_next;
      restr <= chk.restr;
    end
  end

endmodule

// File: rtl/tvgen_top.sv
// top level of the trap vector generator
// capture register then protection checker then vector register
// two tclk edges from the input pins to tvec pviol and restr

`timescale 1ns/1ps

`include "tvgen_defines.svh"

module tvgen_top
  import tvgen_pkg::*;
(
  input  logic                     tclk,
  input  logic                     reset,
  input  logic                     vacc,
  input  logic                     ifetch,
  input  logic                     iwrite,
  input  logic                     iind,
  input  logic [`TVGEN_PT_W-1:0]   pt,
  input  logic [`TVGEN_RING_W-1:0] pcr_ring,
  input  logic                     ftrap_n,
  input  logic                     vtrap_n,
  input  logic                     pan,
  input  logic                     intrq,
  input  logic                     dstop_n,
  input  logic                     poni,
  output logic [`TVGEN_TVEC_W-1:0] tvec,
  output logic                     pviol,
  output logic                     restr
);

  access_t   acc;  // registered access slot
  ext_trap_t ext;  // registered trap pins
  check_t    chk;  // rule results for the slot in acc

  tvgen_access_capture u_access_capture (
    .tclk     (tclk),
    .reset    (reset),
    .vacc     (vacc),
    .ifetch   (ifetch),
    .iwrite   (iwrite),
    .iind     (iind),
    .pt       (pt),
    .pcr_ring (pcr_ring),
    .ftrap_n  (ftrap_n),
    .vtrap_n  (vtrap_n),
    .pan      (pan),
    .intrq    (intrq),
    .dstop_n  (dstop_n),
    .poni     (poni),
    .acc      (acc),
    .ext      (ext)
  );

  tvgen_protect_check u_protect_check (
    .acc (acc),
    .ext (ext),
    .chk (chk)
  );

  tvgen_vector_encode u_vector_encode (
    .tclk  (tclk),
    .reset (reset),
    .chk   (chk),
    .ext   (ext),
    .tvec  (tvec),
    .pviol (pviol),
    .restr (restr)
  );

endmodule

// File: testbench/tvgen_assertions.sv
// concurrent checks on the output register of the trap vector generator
// reset value, pviol against the vector code, dstop hold, restricted mode

`timescale 1ns/1ps

`include "tvgen_defines.svh"

module tvgen_assertions
  import tvgen_pkg::*;
(
  input logic                     tclk,
  input logic                     reset,
  input ext_trap_t                ext,
  input logic [`TVGEN_TVEC_W-1:0] tvec,
  input logic                     pviol,
  input logic                     restr
);

  int fail_count = 0;  // read by the testbench at the end of the run

  a_reset_idle: assert property (@(posedge tclk) reset |=> (tvec == `TVGEN_TV_NONE && !pviol))
    else begin $error("tvec or pviol not cleared after reset"); fail_count++; end

  // only page faults and protection violations raise pviol, and ftrap may cover them
  a_pviol_code: assert property (@(posedge tclk) pviol |->
      (tvec == `TVGEN_TV_FTRAP || tvec == `TVGEN_TV_PGF || tvec == `TVGEN_TV_PVIOL))
    else begin $error("pviol set with vector %h", tvec); fail_count++; end

  a_stop_hold: assert property (@(posedge tclk) disable iff (reset)
      !ext.dstop_n |=> $stable({tvec, pviol, restr}))
    else begin $error("outputs changed while dstop_n was low"); fail_count++; end

  a_restr_poni: assert property (@(posedge tclk) disable iff (reset)
      (!ext.poni && ext.dstop_n) |=> !restr)
    else begin $error("restr set although poni was low"); fail_count++; end

endmodule

bind tvgen_top tvgen_assertions u_assertions (
  .tclk  (tclk),
  .reset (reset),
  .ext   (ext),
  .tvec  (tvec),
  .pviol (pviol),
  .restr (restr)
);

// File: testbench/tvgen_tb.sv
// testbench of the trap vector generator
// directed and random access slots driven on the falling tclk edge
// reference model of the trap rules and the priority table
// compare process that checks every slot two rising edges after it is driven

`timescale 1ns/1ps

`include "tvgen_defines.svh"

module tvgen_tb
  import tvgen_pkg::*;
();

  typedef struct packed {
    access_t   acc;  // access request pins
    ext_trap_t ext;  // external trap pins
  } stim_t;

  typedef struct packed {
    logic [`TVGEN_TVEC_W-1:0] tvec;
    logic                     pviol;
    logic                     restr;
  } expect_t;

  localparam stim_t      IDLE = '{acc: '0, ext: 6'b111010};       // no access, traps inactive
  localparam logic [2:0] KINDS [4] = '{3'b010, 3'b000, 3'b001, 3'b100};  // write read ind fetch

  logic                     tclk;
  logic                     reset;
  logic                     vacc, ifetch, iwrite, iind;
  logic                     ftrap_n, vtrap_n, pan, intrq, dstop_n, poni;
  logic [`TVGEN_PT_W-1:0]   pt;
  logic [`TVGEN_RING_W-1:0] pcr_ring;
  logic [`TVGEN_TVEC_W-1:0] tvec;
  logic                     pviol;
  logic                     restr;
  stim_t                    cur = IDLE;     // slot that sits on the pins right now
  stim_t                    pipe[$];        // captured slots whose outputs are still due
  expect_t                  last_exp = '0;  // reference copy of the output register
  int                       n_pushed = 0;
  int                       n_checked = 0;
  int                       errors = 0;
  int                       test_err0 = 0;  // error count when the current test began
  int                       mark = 0;       // number of the slot driven last

  assign {vacc, ifetch, iwrite, iind, pt, pcr_ring,
          ftrap_n, vtrap_n, pan, intrq, dstop_n, poni} = cur;

  tvgen_top u_tvgen_top (.*);

  initial begin
    tclk = 1'b0;
    forever #20 tclk = ~tclk;  // 40 ns period
  end

  // one valid access with every trap line inactive, kind is {ifetch, iwrite, iind}
  function automatic stim_t make_slot(input logic [2:0] kind, input logic [6:0] pt_word,
                                      input logic [1:0] ring);
    stim_t s;
    s     = IDLE;
    s.acc = {1'b1, kind, pt_word, ring};
    return s;
  endfunction

  // expected outputs of one slot from the rules and the priority table
  function automatic expect_t ref_tvec(input stim_t s);
    expect_t    e;
    pt_fields_t f;
    logic [2:0] kind;
    logic       wr, fe, pgf, prot, rviol, rdown, wip, pgu;
    f     = s.acc.pt.fields;
    kind  = {s.acc.ifetch, s.acc.iwrite, s.acc.iind};
    wr    = s.acc.vacc && (kind == 3'b010);
    fe    = s.acc.vacc && (kind == 3'b100);
    pgf   = s.acc.vacc && !(f.wpm || f.rpm || f.fpm);                    // nothing permitted
    prot  = (wr && !f.wpm) || (fe && !f.fpm)
          || (s.acc.vacc && (kind == 3'b000) && !f.rpm)
          || (s.acc.vacc && (kind == 3'b001) && !f.rpm && !f.fpm);        // indirect needs one
    rviol = s.acc.vacc && (f.ring > s.acc.pcr_ring);
    rdown = fe && f.fpm && (f.ring < s.acc.pcr_ring);
    wip   = wr && f.wpm && !f.wip;
    pgu   = s.acc.vacc && !f.pgu;
    e.pviol = pgf || prot;
    e.restr = s.ext.poni && (s.acc.pcr_ring < 2'd2);                    // vacc plays no part
    casez ({!s.ext.ftrap_n, pgf, prot, rviol, !s.ext.pan, !s.ext.vtrap_n, s.ext.intrq,
            rdown, wip, pgu})
      10'b1?????????: e.tvec = `TVGEN_TV_FTRAP;
      10'b01????????: e.tvec = `TVGEN_TV_PGF;
      10'b001???????: e.tvec = `TVGEN_TV_PVIOL;
      10'b0001??????: e.tvec = `TVGEN_TV_RVIOL;
      10'b00001?????: e.tvec = `TVGEN_TV_PAN;
      10'b000001????: e.tvec = `TVGEN_TV_VTRAP;
      10'b0000001???: e.tvec = `TVGEN_TV_INTRQ;
      10'b00000001??: e.tvec = `TVGEN_TV_RDOWN;
      10'b000000001?: e.tvec = `TVGEN_TV_WIP;
      10'b0000000001: e.tvec = `TVGEN_TV_PGU;
      default:        e.tvec = `TVGEN_TV_NONE;
    endcase
    return e;
  endfunction

  task automatic check_val(input string what, input expect_t got, input expect_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0d ns: %s gave tvec %h pviol %b restr %b, expected %h %b %b",
               $time, what, got.tvec, got.pviol, got.restr, exp.tvec, exp.pviol, exp.restr);
    end
  endtask

  // the DUT captures the pins at a rising edge and answers at the next one
  always @(posedge tclk) begin : compare
    stim_t slot;
    if (!reset) begin
      pipe.push_back(cur);
      n_pushed++;
    end
    #1;                                 // output register has settled
    if (pipe.size() > 1) begin
      slot = pipe.pop_front();
      if (slot.ext.dstop_n)
        last_exp = ref_tvec(slot);      // a stopped slot leaves the register as it was
      n_checked++;
      check_val($sformatf("slot %0d", n_checked), expect_t'{tvec, pviol, restr}, last_exp);
    end
  end

  task automatic drive(input stim_t s);
    @(negedge tclk);
    cur  = s;
    mark = n_pushed + 1;                // it is pushed at the next rising edge
  endtask

  // waits until the last driven slot has been checked, then reports the test
  task automatic end_test(input string name);
    int cycles;
    cycles = 0;
    while (n_checked < mark && cycles < 20) begin
      @(posedge tclk);
      #2;
      cycles++;
    end
    if (n_checked < mark) begin
      errors++;
      $display("%s: timed out waiting for the outputs of the last slot", name);
    end
    $display("%s: done, %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial begin : main
    int          i;
    stim_t       s;
    logic [31:0] rnd;
    void'($urandom(8));                 // fixes the random sequence of the run
    reset = 1'b1;
    repeat (3) @(posedge tclk);
    @(negedge tclk);
    reset = 1'b0;
    check_val("reset", expect_t'{tvec, pviol, restr}, '0);
    repeat (3) drive(IDLE);
    end_test("reset");
    for (i = 0; i < 32; i++) begin
      drive(make_slot(KINDS[i / 8], {i[2:0], 4'b1100}, 2'd0));  // wip and pgu set, ring 0
    end
    end_test("permissions");
    for (i = 0; i < 32; i++) begin
      s = make_slot(3'b100, {5'b11111, i[1:0]}, i[3:2]);        // fetch from a full page
      s.ext.poni = i[4];
      drive(s);
    end
    end_test("rings");
    drive(make_slot(3'b010, 7'b1110100, 2'd0));                 // write with wip clear
    drive(make_slot(3'b000, 7'b1111000, 2'd0));                 // read with pgu clear
    for (i = 0; i < 16; i++) begin
      s = make_slot(3'b010, 7'b1110000, 2'd0);
      s.ext.ftrap_n = !i[0];
      s.ext.pan     = !i[1];
      s.ext.vtrap_n = !i[2];
      s.ext.intrq   = i[3];
      drive(s);
    end
    end_test("updates and priority");
    for (i = 0; i < 12; i++) begin
      s = make_slot(KINDS[i % 4], 7'(i * 37), 2'(i));
      s.ext.dstop_n = (i < 4 || i > 6);                         // frozen for three slots
      drive(s);
    end
    end_test("stop and pipeline");
    for (i = 0; i < 300; i++) begin
      rnd           = $urandom;
      s             = rnd[$bits(stim_t)-1:0];
      s.ext.dstop_n = ($urandom_range(3) != 0);                 // running most of the time
      drive(s);
    end
    end_test("random");
    $display("checked %0d slots, %0d errors, %0d assertion failures", n_checked, errors,
             u_tvgen_top.u_assertions.fail_count);
    if (errors == 0 && u_tvgen_top.u_assertions.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+rtl
rtl/tvgen_pkg.sv
rtl/tvgen_access_capture.sv
rtl/tvgen_protect_check.sv
rtl/tvgen_vector_encode.sv
rtl/tvgen_top.sv
testbench/tvgen_assertions.sv
testbench/tvgen_tb.sv
